//--- vlog.f
design/udp_rx_pkg.sv
design/stage_fifo.sv
design/eth_frame_parser.sv
design/axi_burst_writer.sv
design/udp_rx_top.sv
dv/tb_clock_gen.sv
dv/udp_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module udp_rx_tb -f vlog.f \
	-Mdir obj_dir -o udp_rx_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/udp_rx_sim > sim.log 2>&1
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- dv/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb;
	import udp_rx_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int N_FRAMES     = 47;
	localparam int FRAME_CYCLES = 1000;                  // Slowest frame incl. a B stall
	localparam int DRAIN_CYCLES = 4000;
	localparam int PAY_START    = ETH_LEN + IP_LEN + UDP_LEN + FLAG_LEN;
	localparam logic [47:0] HOST_MAC = 48'h0C9A_3C11_2B47;
	localparam logic [31:0] HOST_IP  = 32'hC0A8_0064;

	logic              clk_125m;
	logic              sys_rst;
	logic [7:0]        i_rx_data;
	logic              i_rx_valid;
	logic              i_rx_last;
	logic              o_rx_ready;
	logic [ID_W-1:0]   o_awid;
	logic [ADDR_W-1:0] o_awaddr;
	logic [LEN_W-1:0]  o_awlen;
	logic              o_awvalid;
	logic              i_awready;
	logic [DATA_W-1:0] o_wdata;
	logic              o_wlast;
	logic              o_wvalid;
	logic              i_wready;
	logic              i_bvalid;
	logic [1:0]        i_bresp;
	logic              o_bready;
	logic [47:0]       o_pc_mac;
	logic [31:0]       o_pc_ip;
	logic              o_trig_arp;
	logic              o_wr_timeout;

	integer seed = 32'h73562b10;
	int     error_count, check_count;
	int     trig_count, timeout_count, b_count, aw_count;
	int     cur_len, beat_idx;
	bit     bp_en, gap_en, hold_b;

	// Reference model state
	logic [47:0] model_mac;
	logic [31:0] model_ip;
	int          exp_trig;
	logic [31:0] flag_tab [4] = '{FLAG_AD, FLAG_MOTOR, FLAG_DDC, FLAG_DDR};
	logic [31:0] base_tab [4] = '{BASE_AD, BASE_MOTOR, BASE_DDC, BASE_DDR};
	int          id_tab [4]   = '{1, 2, 3, 4};
	logic [ADDR_W-1:0] exp_addr [$];
	logic [ID_W-1:0]   exp_id [$];
	int                exp_len [$];
	beat_t             exp_beat [$];

	logic [7:0] frame [0:1023];
	int         frame_len;

	tb_clock_gen i_tb_clock_gen (
		.o_clk_125m (clk_125m),
		.o_sys_rst  (sys_rst)
	);

	udp_rx_top i_udp_rx_top (
		.clk_125m     (clk_125m),
		.sys_rst      (sys_rst),
		.i_rx_data    (i_rx_data),
		.i_rx_valid   (i_rx_valid),
		.i_rx_last    (i_rx_last),
		.o_rx_ready   (o_rx_ready),
		.o_awid       (o_awid),
		.o_awaddr     (o_awaddr),
		.o_awlen      (o_awlen),
		.o_awvalid    (o_awvalid),
		.i_awready    (i_awready),
		.o_wdata      (o_wdata),
		.o_wlast      (o_wlast),
		.o_wvalid     (o_wvalid),
		.i_wready     (i_wready),
		.i_bvalid     (i_bvalid),
		.i_bresp      (i_bresp),
		.o_bready     (o_bready),
		.o_pc_mac     (o_pc_mac),
		.o_pc_ip      (o_pc_ip),
		.o_trig_arp   (o_trig_arp),
		.o_wr_timeout (o_wr_timeout)
	);

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_125m);
			#1;
		end
	endtask

	//****************************************
	// Frame builder
	//****************************************
	task automatic put_field(input logic [47:0] value, input int n_bytes);
		for (int i = n_bytes - 1; i >= 0; i--) begin
			frame[frame_len] = value[i*8 +: 8];              // Network order
			frame_len++;
		end
	endtask

	task automatic build_eth(input logic [47:0] dst, input logic [47:0] src, input logic [15:0] typ);
		frame_len = 0;
		put_field(dst, 6);
		put_field(src, 6);
		put_field(typ, 2);
	endtask

	// Byte source with optional gaps in valid
	task automatic drive_frame();
		logic ready_now;
		for (int i = 0; i < frame_len; i++) begin
			while (gap_en && ($random(seed) & 3) == 0) begin
				i_rx_valid = 1'b0;
				i_rx_last  = 1'b0;
				wait_cycles(1);
			end
			i_rx_valid = 1'b1;
			i_rx_data  = frame[i];
			i_rx_last  = (i == frame_len - 1);
			ready_now  = 1'b0;
			while (!ready_now) begin
				ready_now = o_rx_ready;                      // Stable until the next edge
				wait_cycles(1);
			end
		end
		i_rx_valid = 1'b0;
		i_rx_last  = 1'b0;
	endtask

	task automatic send_arp(input logic [47:0] sha, input logic [31:0] spa, input logic [31:0] tpa);
		build_eth(48'hFFFF_FFFF_FFFF, sha, ETH_TYPE_ARP);
		put_field(16'h0001, 2);
		put_field(16'h0800, 2);
		put_field(8'h06, 1);
		put_field(8'h04, 1);
		put_field(ARP_OP_REQUEST, 2);
		put_field(sha, 6);
		put_field(spa, 4);
		put_field(48'h0, 6);
		put_field(tpa, 4);
		if (tpa == FPGA_IP) begin                        // Only requests for us are learned
			model_mac = sha;
			model_ip  = spa;
			exp_trig++;
		end
		drive_frame();
		wait_cycles(4);
		check_value("arp trigger count", exp_trig, trig_count);
		check_value("o_pc_mac", model_mac, o_pc_mac);
		check_value("o_pc_ip", model_ip, o_pc_ip);
	endtask

	task automatic send_udp(input logic [47:0] dst_mac, input logic [47:0] src_mac,
		input logic [7:0] proto, input logic [31:0] src_ip, input logic [31:0] dst_ip,
		input logic [15:0] port, input logic [31:0] flag, input int pay_len);
		bit known;
		int slot;
		known = 1'b0;
		slot  = 0;
		build_eth(dst_mac, src_mac, ETH_TYPE_IP);
		put_field(IP_VER_IHL, 1);
		put_field(8'h00, 1);
		put_field(16'(IP_LEN + UDP_LEN + FLAG_LEN + pay_len), 2);
		put_field(32'h0000_4000, 4);                     // ID and fragment bits
		put_field(8'h40, 1);
		put_field(proto, 1);
		put_field(16'h0000, 2);
		put_field(src_ip, 4);
		put_field(dst_ip, 4);
		put_field(16'd5000, 2);
		put_field(port, 2);
		put_field(16'(UDP_LEN + FLAG_LEN + pay_len), 2);
		put_field(16'h0000, 2);
		put_field(flag, 4);
		for (int k = 0; k < pay_len; k++)
			put_field(48'($random(seed) & 8'hFF), 1);

		// Acceptance rules and flag table
		for (int k = 0; k < 4; k++) begin
			if (flag == flag_tab[k]) begin
				known = 1'b1;
				slot  = k;
			end
		end
		if (dst_mac == FPGA_MAC && src_mac == model_mac && proto == PROTO_UDP &&
			src_ip == model_ip && dst_ip == FPGA_IP && port == FPGA_PORT && known &&
			pay_len > 0 && pay_len % 2 == 0 && pay_len <= MAX_PAYLOAD) begin
			exp_addr.push_back(base_tab[slot] | SUM_OFFSET);
			exp_id.push_back(ID_W'(id_tab[slot]));
			exp_len.push_back(pay_len / 2 - 1);
			for (int k = 0; k < pay_len; k += 2)
				exp_beat.push_back({frame[PAY_START + k], frame[PAY_START + k + 1]});
		end
		drive_frame();
	endtask

	task automatic send_good();
		logic [31:0] flag;
		int          len;
		flag = flag_tab[$random(seed) & 3];
		len  = 2 * (1 + ($random(seed) & 31));           // 2 to 64 bytes
		send_udp(FPGA_MAC, HOST_MAC, PROTO_UDP, HOST_IP, FPGA_IP, FPGA_PORT, flag, len);
	endtask

	// One rule broken per frame
	task automatic send_broken(input int rule);
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] dst_ip;
		logic [31:0] flag;
		logic [15:0] port;
		logic [7:0]  proto;
		int          len;
		dst_mac = FPGA_MAC;
		src_mac = HOST_MAC;
		dst_ip  = FPGA_IP;
		flag    = FLAG_DDC;
		port    = FPGA_PORT;
		proto   = PROTO_UDP;
		len     = 8;
		case (rule)
			0: port = FPGA_PORT + 16'd1;
			1: flag = 32'h1234_5678;
			2: dst_ip = FPGA_IP ^ 32'h0000_0100;
			3: proto = 8'h06;                                // TCP
			4: src_mac = HOST_MAC ^ 48'h80;
			5: dst_mac = FPGA_MAC ^ 48'h1;
			default: len = 7;
		endcase
		send_udp(dst_mac, src_mac, proto, HOST_IP, dst_ip, port, flag, len);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_addr.size() != 0 || exp_beat.size() != 0 ||
			b_count + timeout_count != aw_count) && n < DRAIN_CYCLES) begin
			wait_cycles(1);
			n++;
		end
		if (n >= DRAIN_CYCLES)
			report_error("expected bursts were not completed in time");
	endtask

	//****************************************
	// Memory side responder
	//****************************************
	always @(posedge clk_125m) begin
		#1;
		i_awready = bp_en ? 1'($random(seed)) : 1'b1;
		i_wready  = bp_en ? 1'($random(seed)) : 1'b1;
		i_bvalid  = hold_b ? 1'b0 : (bp_en ? 1'($random(seed)) : 1'b1);
	end

	// Monitor, sampled mid-cycle ahead of the transfer edge
	always @(negedge clk_125m) begin
		if (!sys_rst) begin
			if (o_trig_arp)
				trig_count++;
			if (o_wr_timeout)
				timeout_count++;
			if (o_bready && i_bvalid)
				b_count++;
			if (o_awvalid && i_awready) begin
				aw_count++;
				if (exp_addr.size() == 0) begin
					report_error("AW transfer seen while no burst was expected");
				end else begin
					cur_len  = exp_len.pop_front();
					beat_idx = 0;
					check_value("o_awaddr", exp_addr.pop_front(), o_awaddr);
					check_value("o_awid", exp_id.pop_front(), o_awid);
					check_value("o_awlen", cur_len, o_awlen);
				end
			end
			if (o_wvalid && i_wready) begin
				if (exp_beat.size() == 0)
					report_error("W beat seen while no data was expected");
				else
					check_value("o_wdata", exp_beat.pop_front(), o_wdata);
				check_value("o_wlast", beat_idx == cur_len, o_wlast);
				beat_idx++;
			end
		end
	end

	initial begin
		#(N_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("RESULT: FAIL");
		$finish;
	end

	//****************************************
	// Test sequence
	//****************************************
	initial begin
		int n;
		i_rx_data  = '0;
		i_rx_valid = 1'b0;
		i_rx_last  = 1'b0;
		i_awready  = 1'b0;
		i_wready   = 1'b0;
		i_bvalid   = 1'b0;
		i_bresp    = 2'b00;
		bp_en      = 1'b0;
		gap_en     = 1'b0;
		hold_b     = 1'b0;
		model_mac  = '0;
		model_ip   = '0;

		// Handshake and status outputs idle while reset is held
		wait_cycles(2);
		check_value("o_rx_ready in reset", 0, o_rx_ready);
		check_value("o_awvalid in reset", 0, o_awvalid);
		check_value("o_wvalid in reset", 0, o_wvalid);
		check_value("o_bready in reset", 0, o_bready);
		check_value("o_trig_arp in reset", 0, o_trig_arp);
		check_value("o_wr_timeout in reset", 0, o_wr_timeout);

		wait (!sys_rst);
		wait_cycles(2);
		check_value("o_pc_mac after reset", 0, o_pc_mac);
		check_value("o_pc_ip after reset", 0, o_pc_ip);

		send_arp(HOST_MAC ^ 48'h1, HOST_IP + 32'd1, FPGA_IP + 32'd1);
		send_arp(HOST_MAC, HOST_IP, FPGA_IP);

		for (int k = 0; k < 4; k++)
			send_udp(FPGA_MAC, HOST_MAC, PROTO_UDP, HOST_IP, FPGA_IP, FPGA_PORT, flag_tab[k], 16);
		drain();

		for (int k = 0; k < 7; k++) begin
			send_broken(k);
			send_good();
		end
		drain();

		bp_en  = 1'b1;
		gap_en = 1'b1;
		repeat (24) send_good();
		drain();

		// B withheld past the writer timeout
		hold_b = 1'b1;
		send_good();
		n = 0;
		while (timeout_count == 0 && n < FRAME_CYCLES) begin
			wait_cycles(1);
			n++;
		end
		wait_cycles(50);
		hold_b = 1'b0;
		check_value("o_wr_timeout pulses", 1, timeout_count);
		send_good();
		drain();
		check_value("o_wr_timeout pulses", 1, timeout_count);

		$display("checks=%0d errors=%0d bursts=%0d arp=%0d timeouts=%0d",
			check_count, error_count, aw_count, trig_count, timeout_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk_125m,
	output logic o_sys_rst
);
	// 8 ns period
	initial begin
		o_clk_125m = 1'b0;
		forever #4 o_clk_125m = ~o_clk_125m;
	end

	initial begin
		o_sys_rst = 1'b1;
		repeat (10) @(posedge o_clk_125m);
		#1 o_sys_rst = 1'b0;                              // Released like any other input
	end

endmodule

//--- design/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top (
	input  logic                         clk_125m,
	input  logic                         sys_rst,
	input  logic [7:0]                   i_rx_data,
	input  logic                         i_rx_valid,
	input  logic                         i_rx_last,
	output logic                         o_rx_ready,
	output logic [udp_rx_pkg::ID_W-1:0]   o_awid,
	output logic [udp_rx_pkg::ADDR_W-1:0] o_awaddr,
	output logic [udp_rx_pkg::LEN_W-1:0]  o_awlen,
	output logic                         o_awvalid,
	input  logic                         i_awready,
	output logic [udp_rx_pkg::DATA_W-1:0] o_wdata,
	output logic                         o_wlast,
	output logic                         o_wvalid,
	input  logic                         i_wready,
	input  logic                         i_bvalid,
	input  logic [1:0]                   i_bresp,
	output logic                         o_bready,
	output logic [47:0]                  o_pc_mac,
	output logic [31:0]                  o_pc_ip,
	output logic                         o_trig_arp,
	output logic                         o_wr_timeout
);
	import udp_rx_pkg::*;

	wr_desc_t desc_in, desc_out;
	beat_t    beat_in, beat_out;
	logic     desc_push, desc_pop, desc_full, desc_empty;
	logic     beat_push, beat_pop, beat_full, beat_empty;

	eth_frame_parser i_eth_frame_parser (
		.clk_125m    (clk_125m),
		.sys_rst     (sys_rst),
		.i_rx_data   (i_rx_data),
		.i_rx_valid  (i_rx_valid),
		.i_rx_last   (i_rx_last),
		.i_desc_full (desc_full),
		.i_beat_full (beat_full),
		.o_rx_ready  (o_rx_ready),
		.o_desc_push (desc_push),
		.o_desc      (desc_in),
		.o_beat_push (beat_push),
		.o_beat      (beat_in),
		.o_pc_mac    (o_pc_mac),
		.o_pc_ip     (o_pc_ip),
		.o_trig_arp  (o_trig_arp)
	);

	// Burst descriptors
	stage_fifo #(.T_PAYLOAD(wr_desc_t), .DEPTH(FIFO_DEPTH)) i_desc_fifo (
		.clk_125m (clk_125m),
		.sys_rst  (sys_rst),
		.i_push   (desc_push),
		.i_data   (desc_in),
		.i_pop    (desc_pop),
		.o_data   (desc_out),
		.o_full   (desc_full),
		.o_empty  (desc_empty)
	);

	// Payload beats, one full frame deep
	stage_fifo #(.T_PAYLOAD(beat_t), .DEPTH(BEAT_FIFO_DEPTH)) i_beat_fifo (
		.clk_125m (clk_125m),
		.sys_rst  (sys_rst),
		.i_push   (beat_push),
		.i_data   (beat_in),
		.i_pop    (beat_pop),
		.o_data   (beat_out),
		.o_full   (beat_full),
		.o_empty  (beat_empty)
	);

	axi_burst_writer i_axi_burst_writer (
		.clk_125m     (clk_125m),
		.sys_rst      (sys_rst),
		.i_desc       (desc_out),
		.i_desc_empty (desc_empty),
		.i_beat       (beat_out),
		.i_beat_empty (beat_empty),
		.i_awready    (i_awready),
		.i_wready     (i_wready),
		.i_bvalid     (i_bvalid),
		.i_bresp      (i_bresp),
		.o_desc_pop   (desc_pop),
		.o_beat_pop   (beat_pop),
		.o_awid       (o_awid),
		.o_awaddr     (o_awaddr),
		.o_awlen      (o_awlen),
		.o_awvalid    (o_awvalid),
		.o_wdata      (o_wdata),
		.o_wlast      (o_wlast),
		.o_wvalid     (o_wvalid),
		.o_bready     (o_bready),
		.o_wr_timeout (o_wr_timeout)
	);

endmodule

//--- design/axi_burst_writer.sv
`timescale 1ns/1ps

module axi_burst_writer (
	input  logic                         clk_125m,
	input  logic                         sys_rst,
	input  udp_rx_pkg::wr_desc_t         i_desc,
	input  logic                         i_desc_empty,
	input  udp_rx_pkg::beat_t            i_beat,
	input  logic                         i_beat_empty,
	input  logic                         i_awready,
	input  logic                         i_wready,
	input  logic                         i_bvalid,
	input  logic [1:0]                   i_bresp,
	output logic                         o_desc_pop,
	output logic                         o_beat_pop,
	output logic [udp_rx_pkg::ID_W-1:0]   o_awid,
	output logic [udp_rx_pkg::ADDR_W-1:0] o_awaddr,
	output logic [udp_rx_pkg::LEN_W-1:0]  o_awlen,
	output logic                         o_awvalid,
	output logic [udp_rx_pkg::DATA_W-1:0] o_wdata,
	output logic                         o_wlast,
	output logic                         o_wvalid,
	output logic                         o_bready,
	output logic                         o_wr_timeout
);
	import udp_rx_pkg::*;

	typedef enum logic [2:0] {W_IDLE, W_ADDR, W_DATA, W_RESP, W_TIMEOUT} wr_state_t;

	wr_state_t         state, state_nx;
	logic [WDOG_W-1:0] wdog;
	logic [LEN_W:0]    beats_rem;                        // Beats not yet popped
	logic              wdog_fire;
	logic              w_fire;

	assign wdog_fire = wdog[WDOG_W-1];
	assign w_fire    = o_wvalid && i_wready;

	//****************************************
	// Burst FSM
	//****************************************
	always_comb begin
		state_nx = state;
		case (state)
			W_IDLE: if (!i_desc_empty) state_nx = W_ADDR;
			W_ADDR: begin
				if (wdog_fire)
					state_nx = W_TIMEOUT;
				else if (i_awready)
					state_nx = W_DATA;
			end
			W_DATA: begin
				if (wdog_fire)
					state_nx = W_TIMEOUT;
				else if (w_fire && o_wlast)
					state_nx = W_RESP;
			end
			W_RESP: begin
				if (wdog_fire)
					state_nx = W_TIMEOUT;
				else if (i_bvalid)
					state_nx = W_IDLE;
			end
			W_TIMEOUT: begin
				// Drain what is left of the abandoned burst
				if (beats_rem == '0 || (o_beat_pop && beats_rem == 1))
					state_nx = W_IDLE;
			end
			default: state_nx = W_IDLE;
		endcase
	end

	always_ff @(posedge clk_125m) begin
		if (sys_rst) begin
			state        <= W_IDLE;
			wdog         <= '0;
			beats_rem    <= '0;
			o_wr_timeout <= 1'b0;
		end else begin
			state        <= state_nx;
			o_wr_timeout <= (state_nx == W_TIMEOUT) && (state != W_TIMEOUT);
			if (state_nx != state || state == W_IDLE || state == W_TIMEOUT)
				wdog <= '0;
			else
				wdog <= wdog + 1'b1;
			if (o_desc_pop)
				beats_rem <= {1'b0, i_desc.len} + 1'b1;
			else if (o_beat_pop)
				beats_rem <= beats_rem - 1'b1;
		end
	end

	// AW fields held for the whole burst
	always_ff @(posedge clk_125m) begin
		if (o_desc_pop) begin
			o_awaddr <= i_desc.addr;
			o_awid   <= i_desc.id;
			o_awlen  <= i_desc.len;
		end
	end

	assign o_desc_pop = (state == W_IDLE) && !i_desc_empty;
	assign o_awvalid  = (state == W_ADDR);
	assign o_wvalid   = (state == W_DATA) && !i_beat_empty;
	assign o_wdata    = i_beat;
	assign o_wlast    = (state == W_DATA) && (beats_rem == 1);
	assign o_bready   = (state == W_RESP);
	assign o_beat_pop = w_fire ||
		((state == W_TIMEOUT) && !i_beat_empty && beats_rem != '0);

	a_aw_stable: assert property (@(posedge clk_125m) disable iff (sys_rst)
		o_awvalid && !i_awready && !wdog_fire |=> o_awvalid && $stable(o_awaddr));
	// Memory side returns OKAY on every write
	a_bresp_okay: assert property (@(posedge clk_125m) disable iff (sys_rst)
		o_bready && i_bvalid |-> i_bresp == 2'b00);

endmodule

//--- design/eth_frame_parser.sv
`timescale 1ns/1ps

module eth_frame_parser (
	input  logic                 clk_125m,
	input  logic                 sys_rst,
	input  logic [7:0]           i_rx_data,
	input  logic                 i_rx_valid,
	input  logic                 i_rx_last,
	input  logic                 i_desc_full,
	input  logic                 i_beat_full,
	output logic                 o_rx_ready,
	output logic                 o_desc_push,
	output udp_rx_pkg::wr_desc_t o_desc,
	output logic                 o_beat_push,
	output udp_rx_pkg::beat_t    o_beat,
	output logic [47:0]          o_pc_mac,
	output logic [31:0]          o_pc_ip,
	output logic                 o_trig_arp
);
	import udp_rx_pkg::*;

	// Absolute byte indices from the start of the frame
	localparam int UDP_BASE  = ETH_LEN + IP_LEN;
	localparam int FLAG_BASE = UDP_BASE + UDP_LEN;
	localparam int HDR_LAST  = FLAG_BASE + FLAG_LEN - 1;
	localparam int ARP_LAST  = ETH_LEN + ARP_LEN - 1;
	localparam int BEAT_SH   = $clog2(BEAT_BYTES);
	localparam int PH_W      = (BEAT_SH > 0) ? BEAT_SH : 1;

	typedef enum logic [2:0] {
		ST_IDLE, ST_ETH, ST_ARP, ST_HDR, ST_DESC, ST_PAYLOAD, ST_DISCARD
	} prs_state_t;

	prs_state_t        state;
	logic [6:0]        byte_cnt;                          // Saturates
	logic [PH_W-1:0]   phase;                             // Byte within beat
	logic [LEN_W:0]    beats_left;
	logic [DATA_W-9:0] beat_sr;
	logic              rx_fire;

	logic [47:0] da_mac, sa_mac, arp_sha;
	logic [31:0] src_ip, dst_ip, flag, arp_spa;
	logic [23:0] arp_tpa_hi;
	logic [15:0] dst_port, udp_len, arp_op;
	logic [7:0]  type_hi, ip_ver, ip_proto;
	logic        arp_ok;

	logic [15:0] pay_len, n_beats, beats_m1;
	logic        hdr_ok, arp_match, arp_accept, phase_last;

	assign rx_fire    = i_rx_valid && o_rx_ready;
	assign phase_last = (phase == PH_W'(BEAT_BYTES - 1));

	// Last target IP byte is still on the bus at index ARP_LAST
	assign arp_match  = (arp_op == ARP_OP_REQUEST) && ({arp_tpa_hi, i_rx_data} == FPGA_IP);
	assign arp_accept = (state == ST_ARP) && rx_fire && i_rx_last &&
		((byte_cnt == ARP_LAST) ? arp_match : (arp_ok && byte_cnt > ARP_LAST));

	assign pay_len  = udp_len - 16'(UDP_LEN + FLAG_LEN);
	assign n_beats  = pay_len >> BEAT_SH;
	assign beats_m1 = n_beats - 16'd1;

	assign hdr_ok = (da_mac == FPGA_MAC) && (sa_mac == o_pc_mac) &&
		(ip_ver == IP_VER_IHL) && (ip_proto == PROTO_UDP) &&
		(src_ip == o_pc_ip) && (dst_ip == FPGA_IP) &&
		(dst_port == FPGA_PORT) && flag_known(flag) &&
		(udp_len > 16'(UDP_LEN + FLAG_LEN)) &&
		((pay_len % BEAT_BYTES) == 0) && (pay_len <= MAX_PAYLOAD);

	always_comb begin
		case (state)
			ST_ETH, ST_ARP, ST_HDR, ST_DISCARD: o_rx_ready = 1'b1;
			ST_PAYLOAD:                         o_rx_ready = !i_beat_full;
			default:                            o_rx_ready = 1'b0;
		endcase
	end

	assign o_desc_push = (state == ST_DESC) && hdr_ok && !i_desc_full;
	assign o_beat_push = (state == ST_PAYLOAD) && rx_fire && phase_last;
	assign o_beat      = {beat_sr, i_rx_data};            // First byte ends up on top

	always_comb begin
		o_desc.addr = flag_base(flag) | SUM_OFFSET;
		o_desc.id   = flag_id(flag);
		o_desc.len  = beats_m1[LEN_W-1:0];
	end

	//****************************************
	// Field capture by byte index
	//****************************************
	always_ff @(posedge clk_125m) begin
		if (rx_fire) begin
			case (state)
				ST_ETH: begin
					if (byte_cnt < 6)
						da_mac <= {da_mac[39:0], i_rx_data};
					else if (byte_cnt < 12)
						sa_mac <= {sa_mac[39:0], i_rx_data};
					else if (byte_cnt == 12)
						type_hi <= i_rx_data;
				end
				ST_HDR: begin
					if (byte_cnt == ETH_LEN)
						ip_ver <= i_rx_data;
					if (byte_cnt == ETH_LEN + 9)
						ip_proto <= i_rx_data;
					if (byte_cnt >= ETH_LEN + 12 && byte_cnt < ETH_LEN + 16)
						src_ip <= {src_ip[23:0], i_rx_data};
					if (byte_cnt >= ETH_LEN + 16 && byte_cnt < UDP_BASE)
						dst_ip <= {dst_ip[23:0], i_rx_data};
					if (byte_cnt == UDP_BASE + 2 || byte_cnt == UDP_BASE + 3)
						dst_port <= {dst_port[7:0], i_rx_data};
					if (byte_cnt == UDP_BASE + 4 || byte_cnt == UDP_BASE + 5)
						udp_len <= {udp_len[7:0], i_rx_data};
					if (byte_cnt >= FLAG_BASE)
						flag <= {flag[23:0], i_rx_data};
				end
				ST_ARP: begin
					if (byte_cnt == ETH_LEN + 6 || byte_cnt == ETH_LEN + 7)
						arp_op <= {arp_op[7:0], i_rx_data};
					if (byte_cnt >= ETH_LEN + 8 && byte_cnt < ETH_LEN + 14)
						arp_sha <= {arp_sha[39:0], i_rx_data};   // Sender MAC
					if (byte_cnt >= ETH_LEN + 14 && byte_cnt < ETH_LEN + 18)
						arp_spa <= {arp_spa[23:0], i_rx_data};   // Sender IP
					if (byte_cnt >= ETH_LEN + 24 && byte_cnt < ARP_LAST)
						arp_tpa_hi <= {arp_tpa_hi[15:0], i_rx_data};
					if (byte_cnt == ARP_LAST)
						arp_ok <= arp_match;
				end
				ST_PAYLOAD: beat_sr <= (DATA_W - 8)'({beat_sr, i_rx_data});
				default: ;
			endcase
		end
	end

	//****************************************
	// Frame FSM
	//****************************************
	always_ff @(posedge clk_125m) begin
		if (sys_rst) begin
			state      <= ST_IDLE;
			byte_cnt   <= '0;
			phase      <= '0;
			beats_left <= '0;
			o_pc_mac   <= '0;
			o_pc_ip    <= '0;
			o_trig_arp <= 1'b0;
		end else begin
			o_trig_arp <= arp_accept;
			if (arp_accept) begin
				o_pc_mac <= arp_sha;
				o_pc_ip  <= arp_spa;
			end
			if (rx_fire && byte_cnt != '1)
				byte_cnt <= byte_cnt + 1'b1;

			case (state)
				ST_IDLE: begin
					byte_cnt <= '0;
					state    <= ST_ETH;
				end
				ST_ETH: if (rx_fire) begin
					if (i_rx_last)
						state <= ST_IDLE;                        // Runt frame
					else if (byte_cnt == ETH_LEN - 1) begin
						if ({type_hi, i_rx_data} == ETH_TYPE_ARP)
							state <= ST_ARP;
						else if ({type_hi, i_rx_data} == ETH_TYPE_IP)
							state <= ST_HDR;
						else
							state <= ST_DISCARD;
					end
				end
				ST_HDR: if (rx_fire) begin
					if (i_rx_last)
						state <= ST_IDLE;
					else if (byte_cnt == HDR_LAST)
						state <= ST_DESC;
				end
				ST_DESC: begin
					phase      <= '0;
					beats_left <= n_beats[LEN_W:0];
					if (!hdr_ok)
						state <= ST_DISCARD;
					else if (!i_desc_full)
						state <= ST_PAYLOAD;                     // Descriptor pushed now
				end
				ST_PAYLOAD: if (rx_fire) begin
					phase <= phase_last ? '0 : phase + 1'b1;
					if (phase_last)
						beats_left <= beats_left - 1'b1;
					if (i_rx_last)
						state <= ST_IDLE;
					else if (phase_last && beats_left == 1)
						state <= ST_DISCARD;                     // Ethernet padding
				end
				ST_ARP, ST_DISCARD: if (rx_fire && i_rx_last) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Each pushed beat is still owed to the open burst
	a_beat_in_burst: assert property (@(posedge clk_125m) disable iff (sys_rst)
		o_beat_push |-> (beats_left != '0));

endmodule

//--- design/stage_fifo.sv
`timescale 1ns/1ps

module stage_fifo #(
	parameter type T_PAYLOAD = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk_125m,
	input  logic     sys_rst,
	input  logic     i_push,
	input  T_PAYLOAD i_data,
	input  logic     i_pop,
	output T_PAYLOAD o_data,
	output logic     o_full,
	output logic     o_empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T_PAYLOAD         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0]   count;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk_125m) begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge clk_125m) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (i_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_data  = mem[rd_ptr];                        // Head word shows without a pop
	assign o_full  = (count == (PTR_W + 1)'(DEPTH));
	assign o_empty = (count == '0);

	a_no_push_full: assert property (@(posedge clk_125m) disable iff (sys_rst)
		i_push |-> !o_full);
	a_no_pop_empty: assert property (@(posedge clk_125m) disable iff (sys_rst)
		i_pop |-> !o_empty);

endmodule

//--- design/udp_rx_pkg.sv
package udp_rx_pkg;

	//****************************************
	// Local addresses
	//****************************************
	localparam logic [47:0] FPGA_MAC  = 48'h00D0_0800_0002;
	localparam logic [31:0] FPGA_IP   = 32'hC0A8_006E;   // 192.168.0.110
	localparam logic [15:0] FPGA_PORT = 16'd8080;

	// Header field values
	localparam logic [15:0] ETH_TYPE_IP    = 16'h0800;
	localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
	localparam logic [7:0]  IP_VER_IHL     = 8'h45;      // IPv4, 20 byte header
	localparam logic [7:0]  PROTO_UDP      = 8'h11;
	localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;

	// Header lengths in bytes
	localparam int ETH_LEN  = 14;
	localparam int IP_LEN   = 20;
	localparam int UDP_LEN  = 8;
	localparam int FLAG_LEN = 4;
	localparam int ARP_LEN  = 28;

	//****************************************
	// Command flags and memory map
	//****************************************
	localparam logic [31:0] FLAG_AD    = 32'hAD86_86DA;
	localparam logic [31:0] FLAG_MOTOR = 32'hE1EC_0C0D;
	localparam logic [31:0] FLAG_DDC   = 32'hDDC0_0264;
	localparam logic [31:0] FLAG_DDR   = 32'hDD30_DD30;

	localparam logic [31:0] BASE_AD    = 32'h4000_0000;
	localparam logic [31:0] BASE_MOTOR = 32'h0000_0000;
	localparam logic [31:0] BASE_DDC   = 32'h8000_0000;
	localparam logic [31:0] BASE_DDR   = 32'hC000_0000;
	localparam logic [31:0] SUM_OFFSET = 32'h0000_0010;

	// AXI side
	localparam int DATA_W     = 16;
	localparam int BEAT_BYTES = DATA_W / 8;
	localparam int ADDR_W     = 32;
	localparam int ID_W       = 4;
	localparam int LEN_W      = 8;                       // AXI awlen

	localparam int MAX_PAYLOAD     = 512;
	localparam int WDOG_W          = 9;                  // MSB set after 256 cycles
	localparam int FIFO_DEPTH      = 4;
	localparam int BEAT_FIFO_DEPTH = MAX_PAYLOAD / BEAT_BYTES;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0]   id;
		logic [LEN_W-1:0]  len;                          // Beats minus one
	} wr_desc_t;

	typedef logic [DATA_W-1:0] beat_t;

	function automatic logic flag_known(input logic [31:0] flag);
		return (flag == FLAG_AD) || (flag == FLAG_MOTOR) ||
			(flag == FLAG_DDC) || (flag == FLAG_DDR);
	endfunction

	function automatic logic [ADDR_W-1:0] flag_base(input logic [31:0] flag);
		case (flag)
			FLAG_AD:    return BASE_AD;
			FLAG_MOTOR: return BASE_MOTOR;
			FLAG_DDC:   return BASE_DDC;
			FLAG_DDR:   return BASE_DDR;
			default:    return '0;
		endcase
	endfunction

	function automatic logic [ID_W-1:0] flag_id(input logic [31:0] flag);
		case (flag)
			FLAG_AD:    return ID_W'(1);
			FLAG_MOTOR: return ID_W'(2);
			FLAG_DDC:   return ID_W'(3);
			FLAG_DDR:   return ID_W'(4);
			default:    return '0;
		endcase
	endfunction

endpackage
